// ==== hdl/geo_pkg.sv ====
// shared types for the line drawing engine: coordinates, opcodes, command and pixel payloads
// compile ahead of every RTL file that imports it
`default_nettype none

package geo_pkg;

  localparam int coord_width = 12;  // signed coordinate bits

  typedef logic signed [coord_width-1:0] coord_t;

  // host opcodes
  typedef enum logic [1:0] {
    op_line    = 2'd0,  // draw a -> b
    op_point_a = 2'd1,  // plot a only
    op_point_b = 2'd2   // plot b only
  } geo_op_t;

  // one host command, sampled on cmd_valid
  typedef struct packed {
    geo_op_t op;
    logic    ink;  // 1 sets, 0 erases
    coord_t  ax;   // start / point a
    coord_t  ay;
    coord_t  bx;   // end / point b
    coord_t  by;
  } geo_cmd_t;

  // generated pixel on its way to the writer
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   ink;
  } pixel_t;

endpackage

`default_nettype wire

// ==== hdl/geo_cmd_decoder.sv ====
// command front end: takes host strobes while idle and launches the line engine or a point
// busy spans a command from acceptance to its last frame buffer write
`timescale 1ns/1ps
`default_nettype none

module geo_cmd_decoder (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_valid,    // one-cycle host strobe
  input  geo_pkg::geo_cmd_t cmd,
  input  logic              engine_busy,  // generator busy or writer still pending
  output logic              run,          // line launch pulse
  output logic              pass_thru_a,  // point a launch pulse
  output logic              pass_thru_b,  // point b launch pulse
  output geo_pkg::coord_t   a_x,
  output geo_pkg::coord_t   a_y,
  output geo_pkg::coord_t   b_x,
  output geo_pkg::coord_t   b_y,
  output logic              ink,          // held for every pixel of the command
  output logic              busy          // host must not strobe while high
);
  import geo_pkg::*;

  logic accept;    // strobe taken this cycle
  logic known_op;  // opcode that launches something
  logic pend;      // command in flight
  logic seen;      // engine_busy has gone high for this command
  logic done;      // engine went quiet again

  always_comb begin
    known_op = (cmd.op == op_line) || (cmd.op == op_point_a) || (cmd.op == op_point_b);
    done     = pend && seen && !engine_busy;
    busy     = pend && !done;                // drops in the cycle the engine settles
    accept   = cmd_valid && !busy;           // strobes during busy are dropped
  end

  // launch pulses, one cycle after the strobe
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      run         <= 1'b0;
      pass_thru_a <= 1'b0;
      pass_thru_b <= 1'b0;
    end else begin
      run         <= accept && (cmd.op == op_line);
      pass_thru_a <= accept && (cmd.op == op_point_a);
      pass_thru_b <= accept && (cmd.op == op_point_b);
    end
  end

  // in-flight tracking: wait for engine_busy to rise and fall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pend <= 1'b0;
      seen <= 1'b0;
    end else if (accept) begin
      pend <= known_op;  // an unknown op launches nothing, so nothing to wait for
      seen <= 1'b0;
    end else if (done) begin
      pend <= 1'b0;
      seen <= 1'b0;
    end else if (pend && engine_busy) begin
      seen <= 1'b1;
    end
  end

  // operands, stable until the next accepted command
  always_ff @(posedge clk) begin
    if (accept) begin
      a_x <= cmd.ax;
      a_y <= cmd.ay;
      b_x <= cmd.bx;
      b_y <= cmd.by;
      ink <= cmd.ink;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/line_generator.sv ====
// bresenham line engine: one pixel per cycle from a to b, plus single-point pass-through
// run is edge detected, and the whole engine freezes while draw_busy is high
`timescale 1ns/1ps
`default_nettype none

module line_generator (
  input  logic            clk,
  input  logic            reset,
  input  logic            run,             // line starts on the rising edge
  input  logic            draw_busy,       // buffer port taken by a host read
  input  logic            pass_thru_a,     // emit a as a single pixel
  input  logic            pass_thru_b,     // emit b as a single pixel
  input  geo_pkg::coord_t a_x,             // line start
  input  geo_pkg::coord_t a_y,
  input  geo_pkg::coord_t b_x,             // line end
  input  geo_pkg::coord_t b_y,
  output logic            busy,            // drawing, final pixel excluded
  output geo_pkg::coord_t x_coord,         // current pixel
  output geo_pkg::coord_t y_coord,
  output logic            pixel_data_rdy,  // x/y valid this cycle
  output logic            line_complete    // high on the last pixel of a line
);
  import geo_pkg::*;

  typedef logic signed [coord_width+2:0] delta_t;  // wide enough for 2*err
  typedef enum logic {
    ph_setup,  // load the error term
    ph_plot    // one step per cycle
  } phase_t;

  phase_t phase;
  logic   last_run;   // run one cycle ago
  logic   req_start;  // launches that arrived during a stall
  logic   req_a;
  logic   req_b;
  logic   draw_line;  // line in progress
  logic   busy_int;   // busy including the final pixel
  logic   run_edge;
  logic   go_start;
  logic   go_a;
  logic   go_b;
  logic   same_pts;   // a == b, one pixel line
  logic   step_x;
  logic   step_y;
  logic   at_end;     // next pixel is the end point
  coord_t xdir;       // -1, 0 or +1
  coord_t ydir;
  coord_t end_x;      // latched end point
  coord_t end_y;
  coord_t x_next;
  coord_t y_next;
  delta_t ax_w;       // sign extended operands
  delta_t ay_w;
  delta_t bx_w;
  delta_t by_w;
  delta_t dx;         // |bx - ax|
  delta_t dy;         // -|by - ay|
  delta_t errd;       // error term
  delta_t e2;
  delta_t err_next;

  always_comb begin
    run_edge = run && !last_run;
    go_start = run_edge || req_start;
    go_a     = pass_thru_a || req_a;
    go_b     = pass_thru_b || req_b;
    same_pts = (a_x == b_x) && (a_y == b_y);
    ax_w     = a_x;
    ay_w     = a_y;
    bx_w     = b_x;
    by_w     = b_y;
    // error rule: step x when 2e >= dy, step y when 2e <= dx
    e2       = errd <<< 1;
    step_x   = e2 >= dy;
    step_y   = e2 <= dx;
    x_next   = step_x ? x_coord + xdir : x_coord;
    y_next   = step_y ? y_coord + ydir : y_coord;
    err_next = errd + (step_x ? dy : delta_t'(0)) + (step_y ? dx : delta_t'(0));
    at_end   = (x_next == end_x) && (y_next == end_y);
    busy     = busy_int && !line_complete;  // free during the final pixel
  end

  // control state
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      last_run       <= 1'b0;
      req_start      <= 1'b0;
      req_a          <= 1'b0;
      req_b          <= 1'b0;
      phase          <= ph_setup;
      draw_line      <= 1'b0;
      busy_int       <= 1'b0;
      pixel_data_rdy <= 1'b0;
      line_complete  <= 1'b0;
    end else begin
      last_run <= run;
      if (draw_busy) begin
        req_start <= go_start;  // keep launch pulses, act once the stall ends
        req_a     <= go_a;
        req_b     <= go_b;
      end else begin
        req_start <= 1'b0;
        req_a     <= 1'b0;
        req_b     <= 1'b0;
        if (go_a || go_b) begin
          pixel_data_rdy <= 1'b1;  // single point next cycle
          line_complete  <= 1'b0;
        end else if (go_start && same_pts) begin
          pixel_data_rdy <= 1'b1;  // degenerate line, done at once
          line_complete  <= 1'b1;
        end else if (go_start) begin
          draw_line      <= 1'b1;
          busy_int       <= 1'b1;
          phase          <= ph_setup;
          pixel_data_rdy <= 1'b0;
          line_complete  <= 1'b0;
        end else if (draw_line) begin
          case (phase)
            ph_setup: begin
              phase          <= ph_plot;
              pixel_data_rdy <= 1'b1;  // start point goes out next
            end
            ph_plot: begin
              if (line_complete) begin  // final pixel is out now
                draw_line      <= 1'b0;
                busy_int       <= 1'b0;
                pixel_data_rdy <= 1'b0;
                line_complete  <= 1'b0;
                phase          <= ph_setup;
              end else begin
                line_complete  <= at_end;
              end
            end
            default: phase <= ph_setup;
          endcase
        end else begin
          pixel_data_rdy <= 1'b0;
          line_complete  <= 1'b0;
        end
      end
    end
  end

  // coordinate and error datapath
  always_ff @(posedge clk) begin
    if (!draw_busy) begin
      if (go_a) begin
        x_coord <= a_x;
        y_coord <= a_y;
      end else if (go_b) begin
        x_coord <= b_x;
        y_coord <= b_y;
      end else if (go_start) begin
        x_coord <= a_x;  // first pixel is the start point
        y_coord <= a_y;
        end_x   <= b_x;
        end_y   <= b_y;
        xdir    <= (b_x < a_x) ? -coord_t'(1) : (b_x == a_x) ? coord_t'(0) : coord_t'(1);
        ydir    <= (b_y < a_y) ? -coord_t'(1) : (b_y == a_y) ? coord_t'(0) : coord_t'(1);
        dx      <= (bx_w > ax_w) ? (bx_w - ax_w) : (ax_w - bx_w);
        dy      <= (ay_w > by_w) ? (by_w - ay_w) : (ay_w - by_w);  // kept negative
      end else if (draw_line && phase == ph_setup) begin
        errd    <= dx + dy;
      end else if (draw_line && !line_complete) begin
        x_coord <= x_next;
        y_coord <= y_next;
        errd    <= err_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/pixel_writer.sv ====
// clips generated pixels to the frame and writes them to the buffer port
// host reads own the port for one cycle and stall the generator through draw_busy
`timescale 1ns/1ps
`default_nettype none

module pixel_writer #(
  parameter int fb_width  = 32,
  parameter int fb_height = 32
) (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic                                           pix_valid,  // generator pixel ready
  input  geo_pkg::pixel_t                                pix,
  input  logic                                           rd_en,      // host read strobe
  input  geo_pkg::coord_t                                rd_x,
  input  geo_pkg::coord_t                                rd_y,
  output logic                                           draw_busy,  // stall the generator
  output logic                                           mem_en,
  output logic                                           mem_we,
  output logic                                           mem_wdata,
  output logic [$clog2(fb_width)+$clog2(fb_height)-1:0] mem_addr,
  output logic                                           rd_valid,   // rd_data valid
  output logic                                           pending     // a write outstanding
);

  localparam int xw = $clog2(fb_width);
  localparam int yw = $clog2(fb_height);
  localparam int aw = xw + yw;

  typedef enum logic {
    st_idle,  // nothing to write
    st_hold   // pixel parked, written when the port is free
  } wr_state_t;

  wr_state_t     state;
  logic          in_frame;  // pixel lands inside the buffer
  logic [aw-1:0] pix_addr;
  logic [aw-1:0] rd_addr;
  logic [aw-1:0] w_addr;    // parked pixel
  logic          w_ink;

  always_comb begin
    in_frame  = (pix.x >= 0) && (pix.x < fb_width) && (pix.y >= 0) && (pix.y < fb_height);
    pix_addr  = {pix.y[yw-1:0], pix.x[xw-1:0]};  // row major
    rd_addr   = {rd_y[yw-1:0], rd_x[xw-1:0]};
    draw_busy = rd_en;                           // reads never wait
    mem_en    = rd_en || (state == st_hold);
    mem_we    = !rd_en && (state == st_hold);
    mem_addr  = rd_en ? rd_addr : w_addr;
    mem_wdata = w_ink;
    pending   = (state == st_hold) || pix_valid;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= st_idle;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;  // registered read in the buffer
      if (!draw_busy) begin
        state <= (pix_valid && in_frame) ? st_hold : st_idle;  // clipped pixels vanish
      end
    end
  end

  // generator is frozen with us during a read, so one entry is enough
  always_ff @(posedge clk) begin
    if (!draw_busy && pix_valid) begin
      w_addr <= pix_addr;
      w_ink  <= pix.ink;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/frame_buffer.sv ====
// one bit per pixel frame store, single port with registered read
// contents start cleared in simulation
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
  parameter int fb_width  = 32,
  parameter int fb_height = 32
) (
  input  logic                                           clk,
  input  logic                                           en,     // port access this cycle
  input  logic                                           we,     // write, else read
  input  logic                                           wdata,
  input  logic [$clog2(fb_width)+$clog2(fb_height)-1:0] addr,
  output logic                                           rdata   // one cycle after en
);

  localparam int depth = fb_width * fb_height;

  logic mem [depth];

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end
      rdata <= mem[addr];  // old data on a write cycle
    end
  end

endmodule

`default_nettype wire

// ==== hdl/line_draw_top.sv ====
// line drawing subsystem: command decoder, bresenham generator, pixel writer, frame buffer
// host issues commands while busy is low and reads pixels back through rd_*
`timescale 1ns/1ps
`default_nettype none

module line_draw_top #(
  parameter int fb_width  = 32,
  parameter int fb_height = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              cmd_valid,
  input  geo_pkg::geo_cmd_t cmd,
  output logic              busy,
  input  logic              rd_en,
  input  geo_pkg::coord_t   rd_x,
  input  geo_pkg::coord_t   rd_y,
  output logic              rd_data,
  output logic              rd_valid
);
  import geo_pkg::*;

  localparam int aw = $clog2(fb_width) + $clog2(fb_height);

  logic          run;
  logic          pass_thru_a;
  logic          pass_thru_b;
  coord_t        a_x;
  coord_t        a_y;
  coord_t        b_x;
  coord_t        b_y;
  logic          ink;
  logic          gen_busy;
  logic          pix_rdy;
  coord_t        x_coord;
  coord_t        y_coord;
  pixel_t        pix;
  logic          draw_busy;
  logic          wr_pending;
  logic          engine_busy;
  logic          mem_en;
  logic          mem_we;
  logic          mem_wdata;
  logic [aw-1:0] mem_addr;

  assign engine_busy = gen_busy || wr_pending;  // command done once both settle
  assign pix         = '{x: x_coord, y: y_coord, ink: ink};

  geo_cmd_decoder u_geo_cmd_decoder (
    .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd), .engine_busy(engine_busy),
    .run(run), .pass_thru_a(pass_thru_a), .pass_thru_b(pass_thru_b),
    .a_x(a_x), .a_y(a_y), .b_x(b_x), .b_y(b_y), .ink(ink), .busy(busy)
  );

  line_generator u_line_generator (
    .clk(clk), .reset(reset), .run(run), .draw_busy(draw_busy),
    .pass_thru_a(pass_thru_a), .pass_thru_b(pass_thru_b),
    .a_x(a_x), .a_y(a_y), .b_x(b_x), .b_y(b_y), .busy(gen_busy),
    .x_coord(x_coord), .y_coord(y_coord), .pixel_data_rdy(pix_rdy), .line_complete()
  );

  pixel_writer #(.fb_width(fb_width), .fb_height(fb_height)) u_pixel_writer (
    .clk(clk), .reset(reset), .pix_valid(pix_rdy), .pix(pix),
    .rd_en(rd_en), .rd_x(rd_x), .rd_y(rd_y), .draw_busy(draw_busy),
    .mem_en(mem_en), .mem_we(mem_we), .mem_wdata(mem_wdata), .mem_addr(mem_addr),
    .rd_valid(rd_valid), .pending(wr_pending)
  );

  frame_buffer #(.fb_width(fb_width), .fb_height(fb_height)) u_frame_buffer (
    .clk(clk), .en(mem_en), .we(mem_we), .wdata(mem_wdata), .addr(mem_addr), .rdata(rd_data)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
// clock and reset source for the line drawing testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns    = 100,
  parameter int reset_cycles = 2
) (
  output logic clk,
  output logic reset  // active high, held over the first rising edges
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;  // released on an edge like every other input
  end

endmodule

`default_nettype wire

// ==== tests/line_draw_tb.sv ====
// testbench for the line drawing subsystem
// drives commands and host reads and checks the frame buffer against a reference bitmap
`timescale 1ns/1ps
`default_nettype none

module line_draw_tb;
  import geo_pkg::*;

  localparam int fb_w     = 32;
  localparam int fb_h     = 32;
  localparam int idle_max = 3000;  // cycles allowed for one wait

  logic     clk;
  logic     reset;
  logic     cmd_valid;
  geo_cmd_t cmd;
  logic     busy;
  logic     rd_en;
  coord_t   rd_x;
  coord_t   rd_y;
  logic     rd_data;
  logic     rd_valid;

  bit          bitmap [fb_w*fb_h];  // expected frame contents in row major order
  logic [15:0] lfsr     = 16'd16525;
  int          checks   = 0;
  int          errors   = 0;
  int          timeouts = 0;

  tb_clock #(.period_ns(100), .reset_cycles(2)) u_tb_clock (.clk(clk), .reset(reset));

  line_draw_top #(.fb_width(fb_w), .fb_height(fb_h)) u_line_draw_top (
    .clk(clk), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd), .busy(busy),
    .rd_en(rd_en), .rd_x(rd_x), .rd_y(rd_y), .rd_data(rd_data), .rd_valid(rd_valid)
  );

  // fibonacci lfsr with taps x^16 x^14 x^13 x^11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int rand_bits(input int n);
    int r;
    int i;
    r = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit taken
      r    = (r << 1) | lfsr[0];
    end
    return r;
  endfunction

  function automatic geo_cmd_t make_cmd(input geo_op_t op, input bit ink,
                                        input int ax, input int ay, input int bx, input int by);
    geo_cmd_t c;
    c.op  = op;
    c.ink = ink;
    c.ax  = coord_t'(ax);
    c.ay  = coord_t'(ay);
    c.bx  = coord_t'(bx);
    c.by  = coord_t'(by);
    return c;
  endfunction

  function automatic void set_pixel(input int x, input int y, input bit ink);
    if (x >= 0 && x < fb_w && y >= 0 && y < fb_h) bitmap[y*fb_w + x] = ink;  // clip
  endfunction

  // reference bresenham that steps x when 2e >= dy and y when 2e <= dx
  function automatic void ref_line(input int x0, input int y0, input int x1, input int y1,
                                   input bit ink);
    int dx, dy, sx, sy, err, e2, x, y, n;
    dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
    dy  = (y1 > y0) ? y0 - y1 : y1 - y0;  // negative magnitude
    sx  = (x0 < x1) ? 1 : -1;
    sy  = (y0 < y1) ? 1 : -1;
    err = dx + dy;
    x   = x0;
    y   = y0;
    for (n = 0; n < 8192; n++) begin
      set_pixel(x, y, ink);
      if (x == x1 && y == y1) break;
      e2 = 2 * err;
      if (e2 >= dy) begin
        err += dy;
        x   += sx;
      end
      if (e2 <= dx) begin
        err += dx;
        y   += sy;
      end
    end
  endfunction

  function automatic void apply_to_bitmap(input geo_cmd_t c);
    case (c.op)
      op_line:    ref_line(c.ax, c.ay, c.bx, c.by, c.ink);
      op_point_a: set_pixel(c.ax, c.ay, c.ink);
      op_point_b: set_pixel(c.bx, c.by, c.ink);
      default:    ;
    endcase
  endfunction

  task automatic expect_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s is %0b, expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic report_and_finish();
    $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    timeouts++;
    $display("timeout at %0t ns: %s", $time, what);
    report_and_finish();
  endtask

  task automatic send_cmd(input geo_cmd_t c);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(posedge clk);
    cmd_valid <= 1'b0;  // single cycle strobe
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy && n < idle_max) begin
      @(negedge clk);
      n++;
    end
    if (busy) abort_on_timeout("busy never fell after a command");
  endtask

  task automatic run_cmd(input geo_cmd_t c);
    send_cmd(c);
    apply_to_bitmap(c);
    @(negedge clk);
    expect_bit("busy", busy, 1'b1);  // high from the cycle after acceptance
    wait_idle();
  endtask

  task automatic read_pixel(input int x, input int y, output logic d);
    @(posedge clk);
    rd_en <= 1'b1;
    rd_x  <= coord_t'(x);
    rd_y  <= coord_t'(y);
    @(negedge clk);
    expect_bit("rd_valid", rd_valid, 1'b0);  // strobe not sampled yet
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    expect_bit("rd_valid", rd_valid, 1'b1);  // exactly one cycle after the strobe
    d = rd_data;
  endtask

  task automatic compare_frame();
    int   x, y;
    logic d;
    for (y = 0; y < fb_h; y++) begin
      for (x = 0; x < fb_w; x++) begin
        read_pixel(x, y, d);
        expect_bit($sformatf("rd_data(%0d,%0d)", x, y), d, bitmap[y*fb_w + x]);
      end
    end
  endtask

  task automatic random_octant_lines();
    int oct, k, x0, y0, major, minor, ddx, ddy;
    for (oct = 0; oct < 8; oct++) begin
      for (k = 0; k < 3; k++) begin
        x0    = rand_bits(6) - 16;  // -16 to 47 and often off the frame
        y0    = rand_bits(6) - 16;
        major = rand_bits(5) + 1;
        minor = rand_bits(5) % (major + 1);
        ddx   = oct[0] ? minor : major;  // odd octants are steep
        ddy   = oct[0] ? major : minor;
        if (oct[1]) ddx = -ddx;
        if (oct[2]) ddy = -ddy;
        run_cmd(make_cmd(op_line, rand_bits(2) != 0, x0, y0, x0 + ddx, y0 + ddy));
        compare_frame();
      end
    end
  endtask

  // host reads interleaved with a long line so that each one stalls the generator
  task automatic reads_during_line();
    int       n, px, py;
    logic     d;
    geo_cmd_t c;
    c = make_cmd(op_line, 1'b1, -3, 2, 34, 29);  // clipped at both ends
    send_cmd(c);
    apply_to_bitmap(c);
    @(negedge clk);
    n = 0;
    while (busy && n < idle_max) begin
      px = rand_bits(5);
      py = rand_bits(5);
      read_pixel(px, py, d);  // the line is still being drawn
      n++;
    end
    if (busy) abort_on_timeout("busy never fell while reads overlapped a line");
    checks++;
    assert (n > 4) else begin
      errors++;
      $display("too few host reads overlapped the line, only %0d", n);
    end
    compare_frame();
  endtask

  initial begin : stimulus
    int       n;
    geo_cmd_t ign;
    cmd_valid = 1'b0;
    cmd       = '0;
    rd_en     = 1'b0;
    rd_x      = '0;
    rd_y      = '0;
    foreach (bitmap[i]) bitmap[i] = 1'b0;  // buffer starts cleared

    @(negedge clk);
    expect_bit("busy", busy, 1'b0);  // still in reset
    expect_bit("rd_valid", rd_valid, 1'b0);
    n = 0;
    while (reset && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (reset) abort_on_timeout("reset was never released");
    expect_bit("busy", busy, 1'b0);
    expect_bit("rd_valid", rd_valid, 1'b0);

    // straight lines inside the frame
    run_cmd(make_cmd(op_line, 1'b1, 2, 5, 28, 5));
    run_cmd(make_cmd(op_line, 1'b1, 7, 1, 7, 30));
    run_cmd(make_cmd(op_line, 1'b1, 0, 0, 31, 31));
    run_cmd(make_cmd(op_line, 1'b1, 31, 2, 2, 31));
    compare_frame();

    // single pixels and erasing
    run_cmd(make_cmd(op_point_a, 1'b1, 20, 3, 9, 12));
    run_cmd(make_cmd(op_point_b, 1'b1, 4, 17, 12, 24));
    run_cmd(make_cmd(op_line, 1'b1, 25, 14, 25, 14));  // degenerate line
    run_cmd(make_cmd(op_point_b, 1'b0, 0, 0, 7, 10));  // erase one pixel of the vertical
    run_cmd(make_cmd(op_line, 1'b0, 2, 5, 10, 5));     // erase part of the horizontal
    compare_frame();

    random_octant_lines();
    reads_during_line();

    // a strobe during busy must leave the frame untouched
    ign = make_cmd(op_point_a, !bitmap[1*fb_w + 30], 30, 1, 0, 0);
    send_cmd(make_cmd(op_line, 1'b1, 0, 0, 31, 20));
    apply_to_bitmap(make_cmd(op_line, 1'b1, 0, 0, 31, 20));
    @(negedge clk);
    expect_bit("busy", busy, 1'b1);
    send_cmd(ign);
    @(negedge clk);
    expect_bit("busy", busy, 1'b1);
    wait_idle();
    compare_frame();

    report_and_finish();
  end

endmodule

`default_nettype wire

// ==== line_draw.f ====
hdl/geo_pkg.sv
hdl/geo_cmd_decoder.sv
hdl/line_generator.sv
hdl/pixel_writer.sv
hdl/frame_buffer.sv
hdl/line_draw_top.sv
tests/tb_clock.sv
tests/line_draw_tb.sv

// ==== Bender.yml ====
package:
  name: line_draw

sources:
  - files:
      - hdl/geo_pkg.sv
      - hdl/geo_cmd_decoder.sv
      - hdl/line_generator.sv
      - hdl/pixel_writer.sv
      - hdl/frame_buffer.sv
      - hdl/line_draw_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/line_draw_tb.sv
